// File: rtl/cpl_rx_pkg.sv
/*
  shared types for the completion receive path
  completions are 3DW-header TLPs on a 64-bit TRN stream, so beat 1 carries
  the first payload dword in its lower half
  completion payloads must hold an even number of dwords
*/
package cpl_rx_pkg;

    typedef logic [63:0] qw_t;
    typedef logic [31:0] dw_t;
    typedef logic [9:0]  len_dw_t;

    localparam logic [6:0] cpl_fmt_type = 7'b1001010; // cpl with data
    localparam logic [2:0] cpl_sc       = 3'b000;     // successful completion

    // first header beat: dw0 above, dw1 below
    typedef struct packed {
        logic       rsvd0;
        logic [6:0] fmt_type;
        logic       rsvd1;
        logic [2:0] tc;
        logic [3:0] rsvd2;
        logic       td;
        logic       ep;
        logic [1:0] attr;
        logic [1:0] rsvd3;
        len_dw_t    len;        // dwords of payload
        logic [15:0] cpl_id;
        logic [2:0]  status;
        logic        bcm;
        logic [11:0] byte_cnt;
    } hdr0_t;

    // second beat: dw2 above, first payload dword below
    typedef struct packed {
        logic [15:0] req_id;
        logic [2:0]  tag_hi;    // unused, tags fit in 5 bits
        logic [4:0]  tag;
        logic        rsvd;
        logic [6:0]  lower_addr;
        dw_t         data;
    } hdr1_t;

    typedef union packed {
        hdr0_t hdr0;
        hdr1_t hdr1;
    } trn_beat_u;

    // host data is big endian per dword
    function automatic dw_t dw_swap(input dw_t d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

endpackage

// File: rtl/rd_req_gen.sv
/*
  splits one buffer descriptor into host read requests
  lbuf_en must be low again by the edge after lbuf_dn
  cfg_max_rd_req_size is a slow level; it is sampled through two registers
  buf_aw must be at least 8 so a 256 qw request fits in a pointer
*/
`timescale 1ns/1ns

module rd_req_gen import cpl_rx_pkg::*; #(
    parameter int         buf_aw   = 9,
    parameter int         tag_w    = 3,
    parameter logic [4:0] tag_base = 5'b00000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              lbuf_en,
    input  qw_t               lbuf_addr,
    input  logic [31:0]       lbuf_len,
    output logic              lbuf_dn,
    input  logic [2:0]        cfg_max_rd_req_size,
    input  logic [buf_aw:0]   committed_cons,
    input  logic [tag_w:0]    retired,
    output qw_t               hst_addr,
    output logic [8:0]        rd_qw,
    output logic [4:0]        rd_tag,
    output logic              rd,
    input  logic              rd_ack,
    output logic              new_rq,
    output logic [tag_w-1:0]  new_rq_tag,
    output logic [buf_aw:0]   new_rq_base,
    output logic [8:0]        new_rq_qw
);

    typedef enum logic [2:0] {s_idle, s_gap, s_chk, s_ack, s_upd} st_t;

    st_t               st;
    logic [1:0]        gap_cnt;     // settle time for the pipeline below
    logic [2:0]        mx_code;
    logic [8:0]        mx_qw;
    logic [8:0]        rq_qw;
    logic [31:0]       len_r;
    logic [31:0]       qw_cnt;
    logic [31:0]       qw_lft;
    logic [buf_aw:0]   iprod;       // issue pointer into the ring
    logic [buf_aw:0]   fill;
    logic [tag_w:0]    issued;
    logic [tag_w:0]    outst;
    logic              space_ok;

    assign rd_tag = {tag_base[4:tag_w], issued[tag_w-1:0]};

    ////////////////////////////////////////////////////////////////////////////
    // free running size and space pipeline, three stages deep
    always_ff @(posedge clk) begin
        mx_code  <= cfg_max_rd_req_size;
        mx_qw    <= (mx_code >= 3'd4) ? 9'd256 : (9'd16 << mx_code); // 4 and 5 both 256
        qw_lft   <= len_r - qw_cnt;
        rq_qw    <= (qw_lft > 32'(mx_qw)) ? mx_qw : qw_lft[8:0];
        fill     <= iprod - committed_cons;
        outst    <= issued - retired;
        space_ok <= ({1'b0, fill} + (buf_aw+2)'(rq_qw)) <= {2'b01, {buf_aw{1'b0}}};
    end

    ////////////////////////////////////////////////////////////////////////////
    // request FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            st      <= s_idle;
            rd      <= 1'b0;
            lbuf_dn <= 1'b0;
            new_rq  <= 1'b0;
            iprod   <= '0;
            issued  <= '0;
            gap_cnt <= '0;
        end else begin
            lbuf_dn <= 1'b0;
            new_rq  <= 1'b0;
            case (st)
                s_idle: begin
                    hst_addr <= lbuf_addr;
                    len_r    <= lbuf_len;
                    qw_cnt   <= '0;
                    gap_cnt  <= '0;
                    if (lbuf_en) begin
                        st <= s_gap;
                    end
                end
                s_gap: begin
                    gap_cnt <= gap_cnt + 2'd1;
                    if (gap_cnt == 2'd2) begin
                        st <= s_chk;
                    end
                end
                s_chk: begin
                    rd_qw <= rq_qw;
                    if (qw_lft == '0) begin
                        lbuf_dn <= 1'b1;             // descriptor fully requested
                        st      <= s_idle;
                    end else if (!outst[tag_w] && space_ok) begin
                        rd <= 1'b1;
                        st <= s_ack;
                    end
                end
                s_ack: begin
                    if (rd_ack) begin
                        rd <= 1'b0;
                        st <= s_upd;
                    end
                end
                s_upd: begin
                    hst_addr    <= hst_addr + qw_t'({rd_qw, 3'b000});
                    qw_cnt      <= qw_cnt + 32'(rd_qw);
                    iprod       <= iprod + (buf_aw+1)'(rd_qw);
                    issued      <= issued + (tag_w+1)'(1);
                    new_rq      <= 1'b1;
                    new_rq_tag  <= issued[tag_w-1:0];
                    new_rq_base <= iprod;
                    new_rq_qw   <= rd_qw;
                    gap_cnt     <= '0;
                    st          <= s_gap;
                end
                default: st <= s_idle;
            endcase
        end
    end

endmodule

// File: rtl/cpl_filter.sv
/*
  completion header walker
  only successful completions with data whose tag upper bits match tag_base
  are passed on; everything else is ignored without any side effect
*/
`timescale 1ns/1ns

module cpl_filter import cpl_rx_pkg::*; #(
    parameter int         tag_w    = 3,
    parameter logic [4:0] tag_base = 5'b00000
) (
    input  logic             clk,
    input  logic             rst,
    input  trn_beat_u        trn_rd,
    input  logic             trn_rsof_n,
    input  logic             trn_rsrc_rdy_n,
    output logic             cnsm,
    output len_dw_t          cpl_len,
    output logic [tag_w-1:0] cpl_tag
);

    logic in_hdr1;  // waiting for the second header beat

    always_ff @(posedge clk) begin
        if (rst) begin
            in_hdr1 <= 1'b0;
            cnsm    <= 1'b0;
        end else begin
            cnsm <= 1'b0;
            if (!trn_rsrc_rdy_n) begin
                if (!in_hdr1) begin
                    cpl_len <= trn_rd.hdr0.len;
                    if (!trn_rsof_n && trn_rd.hdr0.fmt_type == cpl_fmt_type &&
                        trn_rd.hdr0.status == cpl_sc) begin
                        in_hdr1 <= 1'b1;
                    end
                end else begin
                    cpl_tag <= trn_rd.hdr1.tag[tag_w-1:0];
                    if (trn_rd.hdr1.tag[4:tag_w] == tag_base[4:tag_w]) begin
                        cnsm <= 1'b1;           // ours
                    end
                    in_hdr1 <= 1'b0;
                end
            end
        end
    end

endmodule

// File: rtl/cpl_writer.sv
/*
  writes completion payload into the ring buffer
  one qword per payload beat; the lower dword of each beat is held and
  paired with the upper dword of the next one
  assumes even dword counts and quadword aligned requests
*/
`timescale 1ns/1ns

module cpl_writer import cpl_rx_pkg::*; #(
    parameter int buf_aw = 9,
    parameter int tag_w  = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  trn_beat_u         trn_rd,
    input  logic              trn_reof_n,
    input  logic              trn_rsrc_rdy_n,
    input  logic              cnsm,
    input  len_dw_t           cpl_len,
    input  logic [tag_w-1:0]  cpl_tag,
    input  logic              new_rq,
    input  logic [tag_w-1:0]  new_rq_tag,
    input  logic [buf_aw:0]   new_rq_base,
    output logic              wr_en,
    output logic [buf_aw-1:0] wr_addr,
    output qw_t               wr_data,
    output logic              cpl_done,
    output logic [tag_w-1:0]  cpl_done_tag,
    output logic [8:0]        cpl_done_qw
);

    localparam int n_tag = 2 ** tag_w;

    logic [buf_aw-1:0] wa [n_tag];  // next write address per tag
    trn_beat_u         rd_r;
    logic              reof_n_r;
    logic              rdy_n_r;
    logic              busy;
    logic [tag_w-1:0]  tag_r;
    logic [8:0]        qw_r;
    logic [buf_aw-1:0] nxt_addr;
    dw_t               held_dw;

    // one beat of delay so cnsm lines up with the first data beat
    always_ff @(posedge clk) begin
        rd_r     <= trn_rd;
        reof_n_r <= trn_reof_n;
    end

    ////////////////////////////////////////////////////////////////////////////
    // write datapath
    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_n_r  <= 1'b1;
            busy     <= 1'b0;
            wr_en    <= 1'b0;
            cpl_done <= 1'b0;
        end else begin
            rdy_n_r  <= trn_rsrc_rdy_n;
            wr_en    <= 1'b0;
            cpl_done <= 1'b0;

            if (new_rq) begin
                wa[new_rq_tag] <= new_rq_base[buf_aw-1:0];
            end

            if (!busy) begin
                tag_r    <= cpl_tag;
                qw_r     <= cpl_len[9:1];
                nxt_addr <= wa[cpl_tag];
                held_dw  <= rd_r.hdr1.data;         // first payload dword
                if (cnsm) begin
                    busy <= 1'b1;
                end
            end else if (!rdy_n_r) begin
                wr_en    <= 1'b1;
                wr_addr  <= nxt_addr;
                wr_data  <= {dw_swap(rd_r[63:32]), dw_swap(held_dw)};
                held_dw  <= rd_r[31:0];
                nxt_addr <= nxt_addr + buf_aw'(1);
                if (!reof_n_r) begin
                    busy         <= 1'b0;
                    cpl_done     <= 1'b1;
                    cpl_done_tag <= tag_r;
                    cpl_done_qw  <= qw_r;
                    wa[tag_r]    <= nxt_addr + buf_aw'(1); // next cpl of this tag
                end
            end
        end
    end

endmodule

// File: rtl/prod_commit.sv
/*
  in-order producer commit
  a request is retired only when every qword of it has arrived and all
  earlier requests are retired, so committed_prod never exposes a hole
*/
`timescale 1ns/1ns

module prod_commit #(
    parameter int buf_aw = 9,
    parameter int tag_w  = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             new_rq,
    input  logic [tag_w-1:0] new_rq_tag,
    input  logic [buf_aw:0]  new_rq_base,
    input  logic [8:0]       new_rq_qw,
    input  logic             cpl_done,
    input  logic [tag_w-1:0] cpl_done_tag,
    input  logic [8:0]       cpl_done_qw,
    output logic [buf_aw:0]  committed_prod,
    output logic [tag_w:0]   retired
);

    localparam int n_tag = 2 ** tag_w;

    logic [8:0]       rq_len  [n_tag];
    logic [8:0]       rcv_qw  [n_tag];
    logic [buf_aw:0]  end_ptr [n_tag];
    logic [n_tag-1:0] pend;             // issued, not yet retired
    logic [tag_w-1:0] trgt;

    assign trgt = retired[tag_w-1:0];   // oldest outstanding tag

    // per tag bookkeeping
    always_ff @(posedge clk) begin
        if (new_rq) begin
            rq_len[new_rq_tag]  <= new_rq_qw;
            end_ptr[new_rq_tag] <= new_rq_base + (buf_aw+1)'(new_rq_qw);
            rcv_qw[new_rq_tag]  <= '0;
        end
        if (cpl_done) begin
            rcv_qw[cpl_done_tag] <= rcv_qw[cpl_done_tag] + cpl_done_qw;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend           <= '0;
            committed_prod <= '0;
            retired        <= '0;
        end else begin
            if (new_rq) begin
                pend[new_rq_tag] <= 1'b1;
            end
            if (pend[trgt] && rcv_qw[trgt] == rq_len[trgt]) begin
                pend[trgt]     <= 1'b0;
                committed_prod <= end_ptr[trgt];
                retired        <= retired + (tag_w+1)'(1);
            end
        end
    end

endmodule

// File: rtl/cpl_rx_buf.sv
/*
  receive buffer manager for host memory reads
  no back-pressure: the receive stream and the ring write port take every beat
  committed_cons must only move forward, at most one ring size ahead
*/
`timescale 1ns/1ns

module cpl_rx_buf import cpl_rx_pkg::*; #(
    parameter int         buf_aw   = 9,
    parameter int         tag_w    = 3,
    parameter logic [4:0] tag_base = 5'b00000
) (
    input  logic              clk,
    input  logic              rst,
    // TRN receive
    input  trn_beat_u         trn_rd,
    input  logic              trn_rsof_n,
    input  logic              trn_reof_n,
    input  logic              trn_rsrc_rdy_n,
    input  logic [2:0]        cfg_max_rd_req_size,
    // descriptor
    input  logic              lbuf_en,
    input  qw_t               lbuf_addr,
    input  logic [31:0]       lbuf_len,
    output logic              lbuf_dn,
    // host read requests
    output qw_t               hst_addr,
    output logic [8:0]        rd_qw,
    output logic [4:0]        rd_tag,
    output logic              rd,
    input  logic              rd_ack,
    // ring buffer
    output logic              wr_en,
    output logic [buf_aw-1:0] wr_addr,
    output qw_t               wr_data,
    output logic [buf_aw:0]   committed_prod,
    input  logic [buf_aw:0]   committed_cons
);

    logic             new_rq;
    logic [tag_w-1:0] new_rq_tag;
    logic [buf_aw:0]  new_rq_base;
    logic [8:0]       new_rq_qw;
    logic             cnsm;
    len_dw_t          cpl_len;
    logic [tag_w-1:0] cpl_tag;
    logic             cpl_done;
    logic [tag_w-1:0] cpl_done_tag;
    logic [8:0]       cpl_done_qw;
    logic [tag_w:0]   retired;

    rd_req_gen #(.buf_aw(buf_aw), .tag_w(tag_w), .tag_base(tag_base)) rd_req_gen_i (
        .clk, .rst, .lbuf_en, .lbuf_addr, .lbuf_len, .lbuf_dn, .cfg_max_rd_req_size,
        .committed_cons, .retired, .hst_addr, .rd_qw, .rd_tag, .rd, .rd_ack,
        .new_rq, .new_rq_tag, .new_rq_base, .new_rq_qw
    );

    cpl_filter #(.tag_w(tag_w), .tag_base(tag_base)) cpl_filter_i (
        .clk, .rst, .trn_rd, .trn_rsof_n, .trn_rsrc_rdy_n, .cnsm, .cpl_len, .cpl_tag
    );

    cpl_writer #(.buf_aw(buf_aw), .tag_w(tag_w)) cpl_writer_i (
        .clk, .rst, .trn_rd, .trn_reof_n, .trn_rsrc_rdy_n, .cnsm, .cpl_len, .cpl_tag,
        .new_rq, .new_rq_tag, .new_rq_base, .wr_en, .wr_addr, .wr_data,
        .cpl_done, .cpl_done_tag, .cpl_done_qw
    );

    prod_commit #(.buf_aw(buf_aw), .tag_w(tag_w)) prod_commit_i (
        .clk, .rst, .new_rq, .new_rq_tag, .new_rq_base, .new_rq_qw,
        .cpl_done, .cpl_done_tag, .cpl_done_qw, .committed_prod, .retired
    );

endmodule

// File: sim/tb_clk_gen.sv
/*
  testbench clock and reset
  reset is released on the clock edge after rst_cycles rising edges
*/
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int period     = 100,
    parameter int rst_cycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: sim/cpl_rx_buf_tb.sv
/*
  testbench for the completion receive buffer
  a host model acks requests, then returns 16 qword completions once the
  DUT stalls for 40 cycles; pointers and tags carry over between rows
*/
`timescale 1ns/1ns

module cpl_rx_buf_tb import cpl_rx_pkg::*;;

    localparam int n_rows = 5;

    typedef struct {
        qw_t addr;
        int  len;
        int  code;
        bit  rev;   // completions newest first
        bit  hold;  // consumer held until the DUT stalls
        bit  junk;  // foreign TLPs ahead of each batch
    } row_t;

    logic clk, rst;
    trn_beat_u trn_rd;
    logic trn_rsof_n, trn_reof_n, trn_rsrc_rdy_n;
    logic [2:0] cfg_max_rd_req_size;
    logic lbuf_en, lbuf_dn, rd, rd_ack, wr_en;
    qw_t lbuf_addr, hst_addr, wr_data;
    logic [31:0] lbuf_len;
    logic [8:0] rd_qw;
    logic [4:0] rd_tag;
    logic [8:0] wr_addr;
    logic [9:0] committed_prod, committed_cons;

    row_t tbl [n_rows];
    qw_t  host_q [1024];    // host payload by issue offset
    qw_t  exp_mem [512];    // expected ring contents
    int   pend_s [$];
    int   pend_l [$];
    logic [4:0] pend_t [$];
    int   seed, errs, wr_cnt, dn_cnt, iss_abs, cons_abs, seq;

    tb_clk_gen #(.period(100), .rst_cycles(3)) tb_clk_gen_i (.clk, .rst);

    cpl_rx_buf #(.buf_aw(9), .tag_w(3), .tag_base(5'b10000)) cpl_rx_buf_i (.*);

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_qw(input qw_t got, input qw_t exp, input logic [8:0] a);
        if (got !== exp) begin
            errs++;
            $display("Mismatch at %0t: ring[%0d] got %h exp %h", $time, a, got, exp);
        end
    endtask

    task automatic check_ptr(input logic [9:0] got, input logic [9:0] exp, input string what);
        if (got !== exp) begin
            errs++;
            $display("Mismatch at %0t: committed_prod %0d exp %0d %s", $time, got, exp, what);
        end
    endtask

    task automatic check_req(input qw_t a, input logic [8:0] q, input logic [4:0] t,
                             input qw_t ea, input logic [8:0] eq, input logic [4:0] et);
        if (a !== ea || q !== eq || t !== et) begin
            errs++;
            $display("Mismatch at %0t: request %h/%0d/%h exp %h/%0d/%h",
                     $time, a, q, t, ea, eq, et);
        end
    endtask

    function automatic qw_t bswap64(input qw_t q);
        qw_t r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = q[8*(7-i) +: 8];
        end
        return r;
    endfunction

    // largest read request in qwords for each size code
    function automatic int max_qw(input int code);
        case (code)
            0: return 16;
            1: return 32;
            2: return 64;
            3: return 128;
            default: return 256;
        endcase
    endfunction

    // ring write monitor, values sampled before the edge
    always @(posedge clk) begin
        if (wr_en) begin
            wr_cnt++;
            check_qw(wr_data, exp_mem[wr_addr], wr_addr);
        end
        if (lbuf_dn) dn_cnt++;
    end

    always @(negedge clk) begin
        if (lbuf_dn) lbuf_en = 1'b0;    // descriptor finished
    end

    ////////////////////////////////////////////////////////////////////////////
    // host model

    task automatic send_tlp(input logic [6:0] fmt, input logic [2:0] sc,
                            input logic [4:0] tag, input int s, input int nqw);
        trn_beat_u b;
        for (int j = 0; j <= nqw + 1; j++) begin
            @(negedge clk);
            b = '0;
            if (j == 0) begin
                b.hdr0.fmt_type = fmt;
                b.hdr0.status   = sc;
                b.hdr0.len      = len_dw_t'(2 * nqw);
            end else if (j == 1) begin
                b.hdr1.tag  = tag;
                b.hdr1.data = host_q[s % 1024][63:32];
            end else begin
                b[63:32] = host_q[(s + j - 2) % 1024][31:0];
                if (j <= nqw) b[31:0] = host_q[(s + j - 1) % 1024][63:32];
            end
            trn_rd         = b;
            trn_rsof_n     = (j != 0);
            trn_reof_n     = (j != nqw + 1);
            trn_rsrc_rdy_n = 1'b0;
        end
        @(negedge clk);
        trn_rsrc_rdy_n = 1'b1;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
    endtask

    task automatic wait_commit(input int r);
        int n;
        n = 0;
        while (int'(committed_prod) != iss_abs % 1024 && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (n >= 2000) begin
            errs++;
            $display("committed_prod never reached the end of the issued requests at %0t", $time);
        end
        if (!tbl[r].hold) begin
            cons_abs       = iss_abs;
            committed_cons = 10'(cons_abs % 1024);
        end
    endtask

    task automatic flush_cpl(input int r);
        logic [9:0] prior;
        int n, idx, wc0, c;
        prior = committed_prod;
        wc0   = wr_cnt;
        n     = pend_s.size();
        if (tbl[r].junk) begin
            // each as long as the oldest request
            send_tlp(7'b0001010, cpl_sc, pend_t[0], pend_s[0], pend_l[0]); // cpl without data
            send_tlp(cpl_fmt_type, 3'b001, pend_t[0], pend_s[0], pend_l[0]);
            send_tlp(cpl_fmt_type, cpl_sc, {2'b01, pend_t[0][2:0]}, pend_s[0], pend_l[0]);
            repeat (6) @(negedge clk);
            check_ptr(committed_prod, prior, "after foreign TLPs");
            if (wr_cnt != wc0) begin
                errs++;
                $display("foreign TLPs caused ring writes at %0t", $time);
            end
        end
        for (int i = 0; i < n; i++) begin
            idx = tbl[r].rev ? n - 1 - i : i;
            if (tbl[r].rev && n > 1 && i == n - 1) begin
                repeat (8) @(negedge clk);
                check_ptr(committed_prod, prior, "before oldest tag");
            end
            for (int off = 0; off < pend_l[idx]; off += 16) begin
                c = (pend_l[idx] - off < 16) ? pend_l[idx] - off : 16;
                send_tlp(cpl_fmt_type, cpl_sc, pend_t[idx], pend_s[idx] + off, c);
            end
        end
        wait_commit(r);
        pend_s.delete();
        pend_l.delete();
        pend_t.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one table row

    task automatic run_row(input int r);
        int idle, rem, ln, wc0, iss0;
        qw_t ea;
        bit done;
        rem    = tbl[r].len;
        ea     = tbl[r].addr;
        idle   = 0;
        done   = 1'b0;
        wc0    = wr_cnt;
        iss0   = iss_abs;
        dn_cnt = 0;
        @(negedge clk);
        lbuf_addr           = ea;
        lbuf_len            = 32'(rem);
        cfg_max_rd_req_size = 3'(tbl[r].code);
        lbuf_en             = 1'b1;
        while (!done) begin
            @(negedge clk);
            if (rd) begin
                ln = (rem < max_qw(tbl[r].code)) ? rem : max_qw(tbl[r].code);
                check_req(hst_addr, rd_qw, rd_tag, ea, 9'(ln), {2'b10, 3'(seq)});
                if (pend_s.size() >= 8) begin
                    errs++;
                    $display("more than 8 requests outstanding at %0t", $time);
                end
                if (iss_abs + ln - cons_abs > 512) begin
                    errs++;
                    $display("request overruns the free ring space at %0t", $time);
                end
                for (int i = 0; i < ln; i++) begin
                    host_q[(iss_abs + i) % 1024] = {$random(seed), $random(seed)};
                    exp_mem[(iss_abs + i) % 512] = bswap64(host_q[(iss_abs + i) % 1024]);
                end
                pend_s.push_back(iss_abs);
                pend_l.push_back(ln);
                pend_t.push_back({2'b10, 3'(seq)});
                iss_abs += ln;
                rem     -= ln;
                ea      += qw_t'(8 * ln);
                seq++;
                repeat (2) @(negedge clk);
                rd_ack = 1'b1;
                @(negedge clk);
                rd_ack = 1'b0;
                idle   = 0;
            end else begin
                idle = idle + 1;
                if (idle == 40) begin
                    if (pend_s.size() > 0) begin
                        flush_cpl(r);
                    end else if (!lbuf_en) begin
                        done = 1'b1;
                    end else if (cons_abs != iss_abs) begin
                        cons_abs       = iss_abs;   // consumer catches up
                        committed_cons = 10'(cons_abs % 1024);
                    end else begin
                        errs++;
                        $display("request generator stalled with ring space free at %0t", $time);
                        done = 1'b1;
                    end
                    idle = 0;
                end
            end
        end
        if (dn_cnt != 1 || rem != 0) begin
            errs++;
            $display("lbuf_dn pulsed %0d times with %0d qwords unrequested", dn_cnt, rem);
        end
        if (wr_cnt - wc0 != iss_abs - iss0) begin
            errs++;
            $display("%0d ring writes for %0d requested qwords", wr_cnt - wc0, iss_abs - iss0);
        end
        cons_abs       = iss_abs;
        committed_cons = 10'(cons_abs % 1024);
    endtask

    initial begin
        #(n_rows * 20000 * 100);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        int e0;
        seed = 35091;
        errs = 0;
        wr_cnt = 0;
        dn_cnt = 0;
        iss_abs = 0;
        cons_abs = 0;
        seq = 0;
        trn_rd = '0;
        trn_rsof_n = 1'b1;
        trn_reof_n = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        cfg_max_rd_req_size = 3'd0;
        lbuf_en = 1'b0;
        lbuf_addr = '0;
        lbuf_len = '0;
        rd_ack = 1'b0;
        committed_cons = '0;
        // addr, qwords, size code, reversed, consumer hold, foreign TLPs
        tbl[0] = '{64'h0000_0000_1000_0000, 40, 0, 1'b0, 1'b0, 1'b0};
        tbl[1] = '{64'h0000_0002_0000_0100, 300, 2, 1'b1, 1'b0, 1'b1};
        tbl[2] = '{64'h0000_0000_0000_3000, 300, 0, 1'b0, 1'b0, 1'b1};
        tbl[3] = '{64'h0000_0000_4000_0800, 700, 3, 1'b1, 1'b0, 1'b0};
        tbl[4] = '{64'h0000_0000_0000_5000, 600, 5, 1'b0, 1'b1, 1'b0};
        wait (!rst);
        for (int r = 0; r < n_rows; r++) begin
            e0 = errs;
            run_row(r);
            $display("test %0d: %0d qwords, %0d errors", r, tbl[r].len, errs - e0);
        end
        $display("%0d tests run, %0d errors", n_rows, errs);
        if (errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: cpl_rx_buf.f
rtl/cpl_rx_pkg.sv
rtl/rd_req_gen.sv
rtl/cpl_filter.sv
rtl/cpl_writer.sv
rtl/prod_commit.sv
rtl/cpl_rx_buf.sv
sim/tb_clk_gen.sv
sim/cpl_rx_buf_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, result decided from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f cpl_rx_buf.f --top-module cpl_rx_buf_tb \
    && ./obj_dir/Vcpl_rx_buf_tb > sim.log \
    ; cat sim.log 2>/dev/null \
    ; grep -qx "Test passed" sim.log \
    && echo "simulation ok" \
    || { echo "simulation FAILED"; exit 1; }
